//--- addr_trans_top.f
hdl/mmu_pkg.sv
hdl/tlb_match_single.sv
hdl/tlb_fill_ctrl.sv
hdl/dmw_window.sv
hdl/core_addr_trans.sv
hdl/addr_trans_top.sv
test/tb_addr_trans_top.sv

//--- test/tb_addr_trans_top.sv
`default_nettype none

module tb_addr_trans_top;
  timeunit 1ns;
  timeprecision 1ps;

  import mmu_pkg::*;

  localparam int TLB_ENTRY_NUM = 16;
  localparam int IDX_W = $clog2(TLB_ENTRY_NUM);
  localparam asid_t ASID_A = 10'h05a;
  localparam asid_t ASID_B = 10'h1c3;

  typedef logic [IDX_W-1:0] idx_t;

  typedef struct packed {
    logic  e;
    vppn_t vppn;
    asid_t asid;
    logic  g;
    ps_t   ps;
    ppn_t  ppn0;
    logic  v0;
    logic  d0;
    mat_t  mat0;
    plv_t  plv0;
    ppn_t  ppn1;
    logic  v1;
    logic  d1;
    mat_t  mat1;
    plv_t  plv1;
  } tlb_entry_t;

  typedef struct packed {
    vaddr_t addr;
    logic   found;
    logic   dmw;
    idx_t   index;
    ps_t    ps;
    ppn_t   ppn;
    logic   v;
    logic   d;
    mat_t   mat;
    plv_t   plv;
  } result_t;

  logic       clk;
  logic       rst_i;
  logic       crmd_da_i;
  logic       crmd_pg_i;
  plv_t       crmd_plv_i;
  mat_t       crmd_datf_i;
  mat_t       crmd_datm_i;
  dmw_t       dmw0_i;
  dmw_t       dmw1_i;
  asid_t      asid_i;
  logic       tlb_wr_i;
  logic       tlb_fill_i;
  idx_t       w_index_i;
  logic       tlb_inv_all_i;
  tlb_entry_t wr_entry;

  logic   if_valid_i;
  vaddr_t if_vaddr_i;
  logic   if_stall_i;
  logic   if_valid_o;
  logic   if_found_o;
  logic   if_dmw_o;
  idx_t   if_index_o;
  ps_t    if_ps_o;
  ppn_t   if_ppn_o;
  logic   if_v_o;
  logic   if_d_o;
  mat_t   if_mat_o;
  plv_t   if_plv_o;

  logic   dm_valid_i;
  vaddr_t dm_vaddr_i;
  logic   dm_stall_i;
  logic   dm_valid_o;
  logic   dm_found_o;
  logic   dm_dmw_o;
  idx_t   dm_index_o;
  ps_t    dm_ps_o;
  ppn_t   dm_ppn_o;
  logic   dm_v_o;
  logic   dm_d_o;
  mat_t   dm_mat_o;
  plv_t   dm_plv_o;

  tlb_entry_t model_tlb [TLB_ENTRY_NUM];
  int         fill_ptr;
  int         last_slot;
  result_t    if_exp_q[$];
  result_t    dm_exp_q[$];
  int         pass_count;
  int         fail_count;
  int         test_start_fails;
  bit         timed_out;

  addr_trans_top #(
    .TLB_ENTRY_NUM (TLB_ENTRY_NUM)
  ) uut (
    .clk, .rst_i,
    .crmd_da_i, .crmd_pg_i, .crmd_plv_i, .crmd_datf_i, .crmd_datm_i,
    .dmw0_i, .dmw1_i, .asid_i,
    .tlb_wr_i, .tlb_fill_i, .w_index_i, .tlb_inv_all_i,
    .w_vppn_i (wr_entry.vppn), .w_asid_i (wr_entry.asid), .w_g_i (wr_entry.g),
    .w_e_i (wr_entry.e), .w_ps_i (wr_entry.ps),
    .w_ppn0_i (wr_entry.ppn0), .w_v0_i (wr_entry.v0), .w_d0_i (wr_entry.d0),
    .w_mat0_i (wr_entry.mat0), .w_plv0_i (wr_entry.plv0),
    .w_ppn1_i (wr_entry.ppn1), .w_v1_i (wr_entry.v1), .w_d1_i (wr_entry.d1),
    .w_mat1_i (wr_entry.mat1), .w_plv1_i (wr_entry.plv1),
    .if_valid_i, .if_vaddr_i, .if_stall_i,
    .if_valid_o, .if_found_o, .if_dmw_o, .if_index_o, .if_ps_o, .if_ppn_o,
    .if_v_o, .if_d_o, .if_mat_o, .if_plv_o,
    .dm_valid_i, .dm_vaddr_i, .dm_stall_i,
    .dm_valid_o, .dm_found_o, .dm_dmw_o, .dm_index_o, .dm_ps_o, .dm_ppn_o,
    .dm_v_o, .dm_d_o, .dm_mat_o, .dm_plv_o
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic dmw_t make_dmw(logic [2:0] vseg, logic [2:0] pseg, mat_t mat,
                                    logic plv0_en, logic plv3_en);
    return {vseg, 1'b0, pseg, 19'b0, mat, plv3_en, 2'b0, plv0_en};
  endfunction

  function automatic logic window_hit(dmw_t w, vaddr_t a);
    return (a[31:29] == w[31:29]) &&
           ((w[0] && crmd_plv_i == 2'd0) || (w[3] && crmd_plv_i == 2'd3));
  endfunction

  function automatic result_t window_map(dmw_t w, vaddr_t a);
    result_t r;
    r = '0;
    r.addr = a;
    r.found = 1'b1;
    r.dmw = 1'b1;
    r.ps = PS_4K;
    r.ppn = {w[27:25], a[28:12]};
    r.v = 1'b1;
    r.d = 1'b1;
    r.mat = w[5:4];
    r.plv = w[3] ? 2'd3 : 2'd0;
    return r;
  endfunction

  // Expected translation from the CSR levels and the model TLB
  function automatic result_t ref_translate(vaddr_t a, bit fetch);
    result_t    r;
    tlb_entry_t ent;
    logic       big;
    logic       odd;
    r = '0;
    r.addr = a;
    if (crmd_da_i || !crmd_pg_i) begin
      r.found = 1'b1;
      r.dmw = 1'b1;
      r.ps = PS_4K;
      r.ppn = a[31:12];
      r.v = 1'b1;
      r.d = 1'b1;
      r.mat = fetch ? crmd_datf_i : crmd_datm_i;
      r.plv = 2'd3;
    end else if (window_hit(dmw0_i, a)) begin
      r = window_map(dmw0_i, a);
    end else if (window_hit(dmw1_i, a)) begin
      r = window_map(dmw1_i, a);
    end else begin
      for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
        ent = model_tlb[i];
        big = (ent.ps == PS_4M);
        if (ent.e && (ent.g || ent.asid == asid_i) && ent.vppn[18:9] == a[31:22] &&
            (big || ent.vppn[8:0] == a[21:13])) begin
          odd = big ? a[22] : a[12];
          r.found = 1'b1;
          r.index = idx_t'(i);
          r.ps = big ? PS_4M : PS_4K;
          r.ppn = odd ? ent.ppn1 : ent.ppn0;
          r.v = odd ? ent.v1 : ent.v0;
          r.d = odd ? ent.d1 : ent.d0;
          r.mat = odd ? ent.mat1 : ent.mat0;
          r.plv = odd ? ent.plv1 : ent.plv0;
        end
      end
    end
    return r;
  endfunction

  // Top four vppn bits carry the slot so live entries never overlap
  function automatic tlb_entry_t random_entry(int slot);
    tlb_entry_t ent;
    ent = tlb_entry_t'({$urandom, $urandom, $urandom, $urandom});
    ent.e = 1'b1;
    ent.vppn = {4'(slot), 15'($urandom)};
    ent.asid = ($urandom % 2) ? ASID_A : ASID_B;
    ent.g = ($urandom % 4) == 0;
    ent.ps = ($urandom % 2) ? PS_4M : PS_4K;
    return ent;
  endfunction

  function automatic vaddr_t pick_addr(int mode);
    vaddr_t     a;
    tlb_entry_t ent;
    a = $urandom;
    if (mode == 1) begin
      case ($urandom % 3)
        0: a[31:29] = 3'b100;
        1: a[31:29] = 3'b101;
        default: a[31:29] = 3'b011;
      endcase
    end else if (mode >= 2 && ($urandom % 8) != 0) begin
      ent = (mode == 3) ? model_tlb[last_slot] : model_tlb[$urandom % TLB_ENTRY_NUM];
      a[31:13] = ent.vppn;
      if (ent.ps == PS_4M) begin
        a[21:13] = 9'($urandom);
      end
    end
    return a;
  endfunction

  function automatic result_t port_result(bit fetch);
    result_t r;
    r = '0;
    r.found = fetch ? if_found_o : dm_found_o;
    r.dmw = fetch ? if_dmw_o : dm_dmw_o;
    r.index = fetch ? if_index_o : dm_index_o;
    r.ps = fetch ? if_ps_o : dm_ps_o;
    r.ppn = fetch ? if_ppn_o : dm_ppn_o;
    r.v = fetch ? if_v_o : dm_v_o;
    r.d = fetch ? if_d_o : dm_d_o;
    r.mat = fetch ? if_mat_o : dm_mat_o;
    r.plv = fetch ? if_plv_o : dm_plv_o;
    return r;
  endfunction

  task automatic check_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t ns: %s got %b expected %b", $time, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_ppn(string what, ppn_t got, ppn_t exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t ns: %s ppn got %05h expected %05h", $time, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_ps(string what, ps_t got, ps_t exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t ns: %s ps got %0d expected %0d", $time, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_mat_plv(string what, mat_t got_mat, mat_t exp_mat,
                               plv_t got_plv, plv_t exp_plv);
    if (got_mat !== exp_mat || got_plv !== exp_plv) begin
      fail_count++;
      $display("[FAIL] %0t ns: %s mat/plv got %0d/%0d expected %0d/%0d", $time, what,
               got_mat, got_plv, exp_mat, exp_plv);
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_index(string what, idx_t got, idx_t exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t ns: %s index got %0d expected %0d", $time, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  task automatic compare_result(string port, result_t got, result_t exp);
    string what;
    what = $sformatf("%s port vaddr %08h", port, exp.addr);
    check_flag({what, " found"}, got.found, exp.found);
    check_flag({what, " dmw"}, got.dmw, exp.dmw);
    check_flag({what, " v"}, got.v, exp.v);
    check_flag({what, " d"}, got.d, exp.d);
    check_index(what, got.index, exp.index);
    check_ps(what, got.ps, exp.ps);
    check_ppn(what, got.ppn, exp.ppn);
    check_mat_plv(what, got.mat, exp.mat, got.plv, exp.plv);
  endtask

  // Compare process, all inputs and outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
        model_tlb[i].e = 1'b0;
      end
      fill_ptr = 0;
    end else begin
      if (if_valid_o) begin
        if (if_exp_q.size() == 0) begin
          fail_count++;
          $display("Fetch port gave a result with no request outstanding at %0t ns", $time);
        end else begin
          compare_result("fetch", port_result(1'b1), if_exp_q[0]);
          if (!if_stall_i) begin
            void'(if_exp_q.pop_front());
          end
        end
      end
      if (dm_valid_o) begin
        if (dm_exp_q.size() == 0) begin
          fail_count++;
          $display("Data port gave a result with no request outstanding at %0t ns", $time);
        end else begin
          compare_result("data", port_result(1'b0), dm_exp_q[0]);
          if (!dm_stall_i) begin
            void'(dm_exp_q.pop_front());
          end
        end
      end
      if (if_valid_i && !if_stall_i) begin
        if_exp_q.push_back(ref_translate(if_vaddr_i, 1'b1));
      end
      if (dm_valid_i && !dm_stall_i) begin
        dm_exp_q.push_back(ref_translate(dm_vaddr_i, 1'b0));
      end
      // Invalidate acts before a write in the same cycle
      if (tlb_inv_all_i) begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
          model_tlb[i].e = 1'b0;
        end
      end
      if (tlb_wr_i) begin
        model_tlb[w_index_i] = wr_entry;
      end else if (tlb_fill_i) begin
        model_tlb[fill_ptr] = wr_entry;
        fill_ptr = (fill_ptr == TLB_ENTRY_NUM - 1) ? 0 : fill_ptr + 1;
      end
    end
  end

  task automatic finish_run();
    $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(string what);
    $display("Timeout: %s did not complete within its cycle limit", what);
    timed_out = 1'b1;
    finish_run();
  endtask

  task automatic end_test(string name);
    $display("Test %s done with %0d mismatches", name, fail_count - test_start_fails);
    test_start_fails = fail_count;
  endtask

  task automatic wait_results(string what);
    int cycles;
    cycles = 0;
    while ((if_exp_q.size() != 0 || dm_exp_q.size() != 0) && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (if_exp_q.size() != 0 || dm_exp_q.size() != 0) begin
      report_timeout({"results for ", what});
    end
  endtask

  task automatic run_lookups(int n, int mode);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      if_valid_i <= 1'b1;
      if_vaddr_i <= pick_addr(mode);
      dm_valid_i <= 1'b1;
      dm_vaddr_i <= pick_addr(mode);
    end
    @(posedge clk);
    if_valid_i <= 1'b0;
    dm_valid_i <= 1'b0;
    wait_results("lookups");
  endtask

  task automatic tlb_op(bit wr, bit fill, bit inv, int slot);
    @(posedge clk);
    wr_entry <= random_entry(slot);
    w_index_i <= idx_t'(slot);
    tlb_wr_i <= wr;
    tlb_fill_i <= fill;
    tlb_inv_all_i <= inv;
    last_slot = slot;
    @(posedge clk);
    tlb_wr_i <= 1'b0;
    tlb_fill_i <= 1'b0;
    tlb_inv_all_i <= 1'b0;
  endtask

  task automatic run_stalled_stream(int n);
    int if_sent;
    int dm_sent;
    int if_span;
    int dm_span;
    int cycles;
    if_sent = 0;
    dm_sent = 0;
    if_span = 0;
    dm_span = 0;
    cycles = 0;
    while ((if_sent < n || dm_sent < n) && cycles < n * 20) begin
      @(posedge clk);
      cycles++;
      if (if_valid_i && !if_stall_i) if_sent++;
      if (dm_valid_i && !dm_stall_i) dm_sent++;
      // A request not taken on this edge stays on the port
      if (!(if_valid_i && if_stall_i)) begin
        if_valid_i <= (if_sent < n) && ($urandom % 4 != 0);
        if_vaddr_i <= pick_addr(2);
      end
      if (!(dm_valid_i && dm_stall_i)) begin
        dm_valid_i <= (dm_sent < n) && ($urandom % 4 != 0);
        dm_vaddr_i <= pick_addr(2);
      end
      if (if_span == 0) begin
        if_stall_i <= ($urandom % 2) != 0;
        if_span = 1 + $urandom % 4;
      end else begin
        if_span--;
      end
      if (dm_span == 0) begin
        dm_stall_i <= ($urandom % 2) != 0;
        dm_span = 1 + $urandom % 4;
      end else begin
        dm_span--;
      end
    end
    if (if_sent < n || dm_sent < n) begin
      report_timeout("stalled request stream");
    end
    @(posedge clk);
    if_valid_i <= 1'b0;
    dm_valid_i <= 1'b0;
    if_stall_i <= 1'b0;
    dm_stall_i <= 1'b0;
    wait_results("stalled stream");
  endtask

  initial begin
    mat_t       dat_mat;
    logic [2:0] pseg;
    void'($urandom(32'hbb626340));
    rst_i = 1'b1;
    crmd_da_i = 1'b0;
    crmd_pg_i = 1'b0;
    crmd_plv_i = 2'd0;
    crmd_datf_i = 2'd0;
    crmd_datm_i = 2'd0;
    dmw0_i = '0;
    dmw1_i = '0;
    asid_i = ASID_A;
    tlb_wr_i = 1'b0;
    tlb_fill_i = 1'b0;
    w_index_i = '0;
    tlb_inv_all_i = 1'b0;
    wr_entry = '0;
    if_valid_i = 1'b0;
    if_vaddr_i = '0;
    if_stall_i = 1'b0;
    dm_valid_i = 1'b0;
    dm_vaddr_i = '0;
    dm_stall_i = 1'b0;
    for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
      model_tlb[i] = '0;
    end
    fill_ptr = 0;
    last_slot = 0;
    pass_count = 0;
    fail_count = 0;
    test_start_fails = 0;
    timed_out = 1'b0;
    repeat (10) @(posedge clk);
    rst_i <= 1'b0;

    repeat (4) begin
      @(negedge clk);
      check_flag("if_valid_o idle after reset", if_valid_o, 1'b0);
      check_flag("dm_valid_o idle after reset", dm_valid_o, 1'b0);
    end
    end_test("reset");

    // Distinct fetch and data types so the ports can be told apart
    dat_mat = mat_t'($urandom);
    @(posedge clk);
    crmd_da_i <= 1'b1;
    crmd_pg_i <= 1'b0;
    crmd_datf_i <= dat_mat;
    crmd_datm_i <= ~dat_mat;
    run_lookups(12, 0);
    end_test("direct address");

    // Each window maps to its own physical segment
    pseg = 3'($urandom);
    @(posedge clk);
    crmd_da_i <= 1'b0;
    crmd_pg_i <= 1'b1;
    dmw0_i <= make_dmw(3'b100, pseg, mat_t'($urandom), 1'b1, 1'b0);
    dmw1_i <= make_dmw(3'b101, ~pseg, mat_t'($urandom), 1'b0, 1'b1);
    for (int p = 0; p < 4; p++) begin
      @(posedge clk);
      crmd_plv_i <= plv_t'(p);
      run_lookups(6, 1);
    end
    // Overlapping windows, DMW0 must win
    pseg = 3'($urandom);
    @(posedge clk);
    dmw0_i <= make_dmw(3'b100, pseg, mat_t'($urandom), 1'b1, 1'b1);
    dmw1_i <= make_dmw(3'b100, ~pseg, mat_t'($urandom), 1'b1, 1'b1);
    for (int p = 0; p < 4; p += 3) begin
      @(posedge clk);
      crmd_plv_i <= plv_t'(p);
      run_lookups(6, 1);
    end
    end_test("dmw windows");

    @(posedge clk);
    dmw0_i <= '0;
    dmw1_i <= '0;
    crmd_plv_i <= 2'd0;
    for (int k = 0; k < 24; k++) begin
      if ($urandom % 2) begin
        tlb_op(1'b1, 1'b0, 1'b0, int'($urandom % TLB_ENTRY_NUM));
      end else begin
        tlb_op(1'b0, 1'b1, 1'b0, fill_ptr);
      end
    end
    run_lookups(16, 2);
    @(posedge clk);
    asid_i <= ASID_B;
    run_lookups(16, 2);
    end_test("tlb lookup");

    tlb_op(1'b0, 1'b0, 1'b1, 0);
    run_lookups(12, 2);
    tlb_op(1'b1, 1'b0, 1'b1, 5);
    @(posedge clk);
    asid_i <= model_tlb[last_slot].asid;
    run_lookups(6, 3);
    end_test("invalidate all");

    for (int k = 0; k < 8; k++) begin
      tlb_op(1'b0, 1'b1, 1'b0, fill_ptr);
    end
    run_stalled_stream(40);
    end_test("stall");

    finish_run();
  end

endmodule

`default_nettype wire

//--- hdl/addr_trans_top.sv
`default_nettype none

module addr_trans_top #(
  parameter int TLB_ENTRY_NUM = mmu_pkg::TLB_ENTRY_NUM_DEF
) (
  input  logic                             clk,
  input  logic                             rst_i,
  // CSR levels
  input  logic                             crmd_da_i,
  input  logic                             crmd_pg_i,
  input  mmu_pkg::plv_t                    crmd_plv_i,
  input  mmu_pkg::mat_t                    crmd_datf_i,
  input  mmu_pkg::mat_t                    crmd_datm_i,
  input  mmu_pkg::dmw_t                    dmw0_i,
  input  mmu_pkg::dmw_t                    dmw1_i,
  input  mmu_pkg::asid_t                   asid_i,
  // TLB maintenance
  input  logic                             tlb_wr_i,
  input  logic                             tlb_fill_i,
  input  logic [$clog2(TLB_ENTRY_NUM)-1:0] w_index_i,
  input  logic                             tlb_inv_all_i,
  input  mmu_pkg::vppn_t                   w_vppn_i,
  input  mmu_pkg::asid_t                   w_asid_i,
  input  logic                             w_g_i,
  input  logic                             w_e_i,
  input  mmu_pkg::ps_t                     w_ps_i,
  input  mmu_pkg::ppn_t                    w_ppn0_i,
  input  logic                             w_v0_i,
  input  logic                             w_d0_i,
  input  mmu_pkg::mat_t                    w_mat0_i,
  input  mmu_pkg::plv_t                    w_plv0_i,
  input  mmu_pkg::ppn_t                    w_ppn1_i,
  input  logic                             w_v1_i,
  input  logic                             w_d1_i,
  input  mmu_pkg::mat_t                    w_mat1_i,
  input  mmu_pkg::plv_t                    w_plv1_i,
  // Fetch port
  input  logic                             if_valid_i,
  input  mmu_pkg::vaddr_t                  if_vaddr_i,
  input  logic                             if_stall_i,
  output logic                             if_valid_o,
  output logic                             if_found_o,
  output logic                             if_dmw_o,
  output logic [$clog2(TLB_ENTRY_NUM)-1:0] if_index_o,
  output mmu_pkg::ps_t                     if_ps_o,
  output mmu_pkg::ppn_t                    if_ppn_o,
  output logic                             if_v_o,
  output logic                             if_d_o,
  output mmu_pkg::mat_t                    if_mat_o,
  output mmu_pkg::plv_t                    if_plv_o,
  // Data port
  input  logic                             dm_valid_i,
  input  mmu_pkg::vaddr_t                  dm_vaddr_i,
  input  logic                             dm_stall_i,
  output logic                             dm_valid_o,
  output logic                             dm_found_o,
  output logic                             dm_dmw_o,
  output logic [$clog2(TLB_ENTRY_NUM)-1:0] dm_index_o,
  output mmu_pkg::ps_t                     dm_ps_o,
  output mmu_pkg::ppn_t                    dm_ppn_o,
  output logic                             dm_v_o,
  output logic                             dm_d_o,
  output mmu_pkg::mat_t                    dm_mat_o,
  output mmu_pkg::plv_t                    dm_plv_o
);
  logic [TLB_ENTRY_NUM-1:0] tlb_we;

  tlb_fill_ctrl #(
    .TLB_ENTRY_NUM (TLB_ENTRY_NUM)
  ) u_fill_ctrl (
    .clk, .rst_i, .tlb_wr_i, .tlb_fill_i, .w_index_i,
    .tlb_we_o (tlb_we)
  );

  // Both translators see the same entry writes
  core_addr_trans #(
    .TLB_ENTRY_NUM (TLB_ENTRY_NUM),
    .FETCH_ADDR    (1'b1)
  ) u_fetch_trans (
    .clk, .rst_i,
    .valid_i (if_valid_i), .vaddr_i (if_vaddr_i), .stall_i (if_stall_i),
    .crmd_da_i, .crmd_pg_i, .crmd_plv_i, .crmd_datf_i, .crmd_datm_i,
    .dmw0_i, .dmw1_i, .asid_i,
    .tlb_we_i (tlb_we), .tlb_inv_all_i,
    .w_vppn_i, .w_asid_i, .w_g_i, .w_e_i, .w_ps_i,
    .w_ppn0_i, .w_v0_i, .w_d0_i, .w_mat0_i, .w_plv0_i,
    .w_ppn1_i, .w_v1_i, .w_d1_i, .w_mat1_i, .w_plv1_i,
    .valid_o (if_valid_o), .found_o (if_found_o), .dmw_o (if_dmw_o),
    .index_o (if_index_o), .ps_o (if_ps_o), .ppn_o (if_ppn_o),
    .v_o (if_v_o), .d_o (if_d_o), .mat_o (if_mat_o), .plv_o (if_plv_o)
  );

  core_addr_trans #(
    .TLB_ENTRY_NUM (TLB_ENTRY_NUM),
    .FETCH_ADDR    (1'b0)
  ) u_data_trans (
    .clk, .rst_i,
    .valid_i (dm_valid_i), .vaddr_i (dm_vaddr_i), .stall_i (dm_stall_i),
    .crmd_da_i, .crmd_pg_i, .crmd_plv_i, .crmd_datf_i, .crmd_datm_i,
    .dmw0_i, .dmw1_i, .asid_i,
    .tlb_we_i (tlb_we), .tlb_inv_all_i,
    .w_vppn_i, .w_asid_i, .w_g_i, .w_e_i, .w_ps_i,
    .w_ppn0_i, .w_v0_i, .w_d0_i, .w_mat0_i, .w_plv0_i,
    .w_ppn1_i, .w_v1_i, .w_d1_i, .w_mat1_i, .w_plv1_i,
    .valid_o (dm_valid_o), .found_o (dm_found_o), .dmw_o (dm_dmw_o),
    .index_o (dm_index_o), .ps_o (dm_ps_o), .ppn_o (dm_ppn_o),
    .v_o (dm_v_o), .d_o (dm_d_o), .mat_o (dm_mat_o), .plv_o (dm_plv_o)
  );

endmodule

`default_nettype wire

//--- hdl/core_addr_trans.sv
`default_nettype none

module core_addr_trans #(
  parameter int TLB_ENTRY_NUM = mmu_pkg::TLB_ENTRY_NUM_DEF,
  parameter bit FETCH_ADDR    = 1'b0
) (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic                             valid_i,
  input  mmu_pkg::vaddr_t                  vaddr_i,
  input  logic                             stall_i,
  input  logic                             crmd_da_i,
  input  logic                             crmd_pg_i,
  input  mmu_pkg::plv_t                    crmd_plv_i,
  input  mmu_pkg::mat_t                    crmd_datf_i,
  input  mmu_pkg::mat_t                    crmd_datm_i,
  input  mmu_pkg::dmw_t                    dmw0_i,
  input  mmu_pkg::dmw_t                    dmw1_i,
  input  mmu_pkg::asid_t                   asid_i,
  input  logic [TLB_ENTRY_NUM-1:0]         tlb_we_i,
  input  logic                             tlb_inv_all_i,
  input  mmu_pkg::vppn_t                   w_vppn_i,
  input  mmu_pkg::asid_t                   w_asid_i,
  input  logic                             w_g_i,
  input  logic                             w_e_i,
  input  mmu_pkg::ps_t                     w_ps_i,
  input  mmu_pkg::ppn_t                    w_ppn0_i,
  input  logic                             w_v0_i,
  input  logic                             w_d0_i,
  input  mmu_pkg::mat_t                    w_mat0_i,
  input  mmu_pkg::plv_t                    w_plv0_i,
  input  mmu_pkg::ppn_t                    w_ppn1_i,
  input  logic                             w_v1_i,
  input  logic                             w_d1_i,
  input  mmu_pkg::mat_t                    w_mat1_i,
  input  mmu_pkg::plv_t                    w_plv1_i,
  output logic                             valid_o,
  output logic                             found_o,
  output logic                             dmw_o,
  output logic [$clog2(TLB_ENTRY_NUM)-1:0] index_o,
  output mmu_pkg::ps_t                     ps_o,
  output mmu_pkg::ppn_t                    ppn_o,
  output logic                             v_o,
  output logic                             d_o,
  output mmu_pkg::mat_t                    mat_o,
  output mmu_pkg::plv_t                    plv_o
);
  import mmu_pkg::*;

  localparam int IDX_W = $clog2(TLB_ENTRY_NUM);

  logic [TLB_ENTRY_NUM-1:0] tlb_match;
  logic [TLB_ENTRY_NUM-1:0] odd_page;

  // Per-entry page values, [1] is the odd page
  ppn_t [1:0]               ppn_q [TLB_ENTRY_NUM];
  logic [1:0]               v_q   [TLB_ENTRY_NUM];
  logic [1:0]               d_q   [TLB_ENTRY_NUM];
  mat_t [1:0]               mat_q [TLB_ENTRY_NUM];
  plv_t [1:0]               plv_q [TLB_ENTRY_NUM];
  logic [TLB_ENTRY_NUM-1:0] is_4m_q;

  logic             tlb_found;
  logic [IDX_W-1:0] tlb_index;
  ps_t              tlb_ps;
  ppn_t             tlb_ppn;
  logic             tlb_v;
  logic             tlb_d;
  mat_t             tlb_mat;
  plv_t             tlb_plv;

  logic da_mode;
  logic dmw0_hit;
  logic dmw1_hit;
  ppn_t dmw0_ppn;
  ppn_t dmw1_ppn;
  mat_t dmw0_mat;
  mat_t dmw1_mat;
  plv_t dmw0_plv;
  plv_t dmw1_plv;

  logic             nxt_found;
  logic             nxt_dmw;
  logic [IDX_W-1:0] nxt_index;
  ps_t              nxt_ps;
  ppn_t             nxt_ppn;
  logic             nxt_v;
  logic             nxt_d;
  mat_t             nxt_mat;
  plv_t             nxt_plv;

  for (genvar i = 0; i < TLB_ENTRY_NUM; i++) begin : g_entry
    tlb_match_single u_match (
      .clk, .rst_i,
      .vppn_i    (vaddr_i[31:13]),
      .asid_i,
      .update_i  (tlb_we_i[i]),
      .inv_all_i (tlb_inv_all_i),
      .w_vppn_i, .w_asid_i, .w_g_i, .w_e_i, .w_ps_i,
      .match_o   (tlb_match[i])
    );
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
      if (tlb_we_i[i]) begin
        ppn_q[i]   <= {w_ppn1_i, w_ppn0_i};
        v_q[i]     <= {w_v1_i, w_v0_i};
        d_q[i]     <= {w_d1_i, w_d0_i};
        mat_q[i]   <= {w_mat1_i, w_mat0_i};
        plv_q[i]   <= {w_plv1_i, w_plv0_i};
        is_4m_q[i] <= (w_ps_i == PS_4M);
      end
    end
  end

  // Odd/even select bit depends on each entry's page size
  always_comb begin
    for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
      odd_page[i] = is_4m_q[i] ? vaddr_i[22] : vaddr_i[12];
    end
  end

  // Matches are one-hot so OR-merging is enough
  always_comb begin
    tlb_found = 1'b0;
    tlb_index = '0;
    tlb_ps    = '0;
    tlb_ppn   = '0;
    tlb_v     = 1'b0;
    tlb_d     = 1'b0;
    tlb_mat   = '0;
    tlb_plv   = '0;
    for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
      if (tlb_match[i]) begin
        tlb_found = 1'b1;
        tlb_index |= IDX_W'(i);
        tlb_ps    |= is_4m_q[i] ? PS_4M : PS_4K;
        tlb_ppn   |= ppn_q[i][odd_page[i]];
        tlb_v     |= v_q[i][odd_page[i]];
        tlb_d     |= d_q[i][odd_page[i]];
        tlb_mat   |= mat_q[i][odd_page[i]];
        tlb_plv   |= plv_q[i][odd_page[i]];
      end
    end
  end

  dmw_window u_dmw0 (
    .vaddr_i, .dmw_i(dmw0_i), .plv_i(crmd_plv_i),
    .hit_o(dmw0_hit), .ppn_o(dmw0_ppn), .mat_o(dmw0_mat), .plv_o(dmw0_plv)
  );

  dmw_window u_dmw1 (
    .vaddr_i, .dmw_i(dmw1_i), .plv_i(crmd_plv_i),
    .hit_o(dmw1_hit), .ppn_o(dmw1_ppn), .mat_o(dmw1_mat), .plv_o(dmw1_plv)
  );

  // Direct address when DA is set or paging is off
  assign da_mode = crmd_da_i || !crmd_pg_i;

  always_comb begin
    nxt_found = tlb_found;
    nxt_dmw   = 1'b0;
    nxt_index = tlb_index;
    nxt_ps    = tlb_ps;
    nxt_ppn   = tlb_ppn;
    nxt_v     = tlb_v;
    nxt_d     = tlb_d;
    nxt_mat   = tlb_mat;
    nxt_plv   = tlb_plv;
    if (da_mode || dmw0_hit || dmw1_hit) begin
      nxt_found = 1'b1;
      nxt_dmw   = 1'b1;
      nxt_index = '0;
      nxt_ps    = PS_4K;
      nxt_v     = 1'b1;
      nxt_d     = 1'b1;
      if (da_mode) begin
        nxt_ppn = vaddr_i[31:12];
        nxt_mat = FETCH_ADDR ? crmd_datf_i : crmd_datm_i;
        nxt_plv = 2'd3;
      end else if (dmw0_hit) begin
        nxt_ppn = dmw0_ppn;
        nxt_mat = dmw0_mat;
        nxt_plv = dmw0_plv;
      end else begin
        nxt_ppn = dmw1_ppn;
        nxt_mat = dmw1_mat;
        nxt_plv = dmw1_plv;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  // Result held while the next stage stalls
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      found_o <= nxt_found;
      dmw_o   <= nxt_dmw;
      index_o <= nxt_index;
      ps_o    <= nxt_ps;
      ppn_o   <= nxt_ppn;
      v_o     <= nxt_v;
      d_o     <= nxt_d;
      mat_o   <= nxt_mat;
      plv_o   <= nxt_plv;
    end
  end

  assert property (@(posedge clk) disable iff (rst_i)
    valid_i |-> $onehot0(tlb_match))
    else $error("core_addr_trans: several TLB entries match one address");

endmodule

`default_nettype wire

//--- hdl/dmw_window.sv
`default_nettype none

module dmw_window (
  input  mmu_pkg::vaddr_t vaddr_i,
  input  mmu_pkg::dmw_t   dmw_i,
  input  mmu_pkg::plv_t   plv_i,
  output logic            hit_o,
  output mmu_pkg::ppn_t   ppn_o,
  output mmu_pkg::mat_t   mat_o,
  output mmu_pkg::plv_t   plv_o
);
  logic seg_hit;
  logic plv_ok;
  logic plv0_en;
  logic plv3_en;

  assign plv0_en = dmw_i[0];
  assign plv3_en = dmw_i[3];

  assign seg_hit = (vaddr_i[31:29] == dmw_i[31:29]);

  // Only levels 0 and 3 have an enable bit
  assign plv_ok = (plv0_en && (plv_i == 2'd0)) ||
                  (plv3_en && (plv_i == 2'd3));

  assign hit_o = seg_hit && plv_ok;

  // Physical segment replaces the top three address bits
  assign ppn_o = {dmw_i[27:25], vaddr_i[28:12]};
  assign mat_o = dmw_i[5:4];
  assign plv_o = plv3_en ? 2'd3 : 2'd0;

endmodule

`default_nettype wire

//--- hdl/tlb_fill_ctrl.sv
`default_nettype none

module tlb_fill_ctrl #(
  parameter int TLB_ENTRY_NUM = mmu_pkg::TLB_ENTRY_NUM_DEF
) (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic                             tlb_wr_i,
  input  logic                             tlb_fill_i,
  input  logic [$clog2(TLB_ENTRY_NUM)-1:0] w_index_i,
  output logic [TLB_ENTRY_NUM-1:0]         tlb_we_o
);
  localparam int IDX_W = $clog2(TLB_ENTRY_NUM);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(TLB_ENTRY_NUM - 1);

  logic [IDX_W-1:0] fill_ptr_q;

  // Round-robin victim pointer
  always_ff @(posedge clk) begin
    if (rst_i) begin
      fill_ptr_q <= '0;
    end else if (tlb_fill_i) begin
      fill_ptr_q <= (fill_ptr_q == LAST_IDX) ? '0 : fill_ptr_q + 1'b1;
    end
  end

  always_comb begin
    tlb_we_o = '0;
    if (tlb_wr_i) begin
      tlb_we_o[w_index_i] = 1'b1;
    end else if (tlb_fill_i) begin
      tlb_we_o[fill_ptr_q] = 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (rst_i)
    !(tlb_wr_i && tlb_fill_i))
    else $error("tlb_fill_ctrl: write and fill requested together");

  // An index past the last entry would drop the write
  assert property (@(posedge clk) disable iff (rst_i)
    (tlb_wr_i || tlb_fill_i) |-> $onehot(tlb_we_o))
    else $error("tlb_fill_ctrl: request without exactly one entry write enable");

endmodule

`default_nettype wire

//--- hdl/tlb_match_single.sv
`default_nettype none

module tlb_match_single (
  input  logic           clk,
  input  logic           rst_i,
  input  mmu_pkg::vppn_t vppn_i,
  input  mmu_pkg::asid_t asid_i,
  input  logic           update_i,
  input  logic           inv_all_i,
  input  mmu_pkg::vppn_t w_vppn_i,
  input  mmu_pkg::asid_t w_asid_i,
  input  logic           w_g_i,
  input  logic           w_e_i,
  input  mmu_pkg::ps_t   w_ps_i,
  output logic           match_o
);
  import mmu_pkg::*;

  logic  e_q;
  vppn_t vppn_q;
  asid_t asid_q;
  logic  g_q;
  logic  is_4m_q;
  logic  asid_hit;
  logic  vppn_hi_hit;
  logic  vppn_lo_hit;

  // A write in the same cycle as invalidate-all wins
  always_ff @(posedge clk) begin
    if (rst_i) begin
      e_q <= 1'b0;
    end else if (update_i) begin
      e_q <= w_e_i;
    end else if (inv_all_i) begin
      e_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (update_i) begin
      vppn_q  <= w_vppn_i;
      asid_q  <= w_asid_i;
      g_q     <= w_g_i;
      is_4m_q <= (w_ps_i == PS_4M);
    end
  end

  assign asid_hit    = g_q || (asid_q == asid_i);
  assign vppn_hi_hit = (vppn_q[18:9] == vppn_i[18:9]);
  // 4M pages ignore the low vppn bits
  assign vppn_lo_hit = is_4m_q || (vppn_q[8:0] == vppn_i[8:0]);

  assign match_o = e_q && asid_hit && vppn_hi_hit && vppn_lo_hit;

endmodule

`default_nettype wire

//--- hdl/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

  // Default TLB depth when a module is used on its own
  localparam int TLB_ENTRY_NUM_DEF = 16;

  typedef logic [31:0] vaddr_t;

  // Virtual page pair number, vaddr[31:13]
  typedef logic [18:0] vppn_t;

  typedef logic [19:0] ppn_t;
  typedef logic [9:0]  asid_t;

  // Page size as log2 of bytes
  typedef logic [5:0]  ps_t;

  typedef logic [1:0]  mat_t;
  typedef logic [1:0]  plv_t;

  // DMW CSR layout
  //   [0]     PLV0 enable
  //   [3]     PLV3 enable
  //   [5:4]   MAT
  //   [27:25] physical segment
  //   [31:29] virtual segment
  typedef logic [31:0] dmw_t;

  localparam ps_t PS_4K = 6'd12;
  localparam ps_t PS_4M = 6'd22;

endpackage

`default_nettype wire
